// File: common/icache_cfg_pkg.sv
// --------------------------------------------------
// Instruction cache geometry
// Fixed sizes and the width types derived from them
// --------------------------------------------------
`default_nettype none

package icache_cfg_pkg;

    // Fetch side
    localparam int unsigned FETCH_AW = 32;
    localparam int unsigned ID_WIDTH = 4;

    // Line organisation
    localparam int unsigned LINE_WIDTH = 64;
    localparam int unsigned LINE_COUNT = 16;
    localparam int unsigned SET_COUNT  = 2;

    // Address split into tag, line index and byte offset
    localparam int unsigned LINE_ALIGN  = $clog2(LINE_WIDTH / 8);
    localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT);
    localparam int unsigned SET_ALIGN   = $clog2(SET_COUNT);
    localparam int unsigned TAG_WIDTH   = FETCH_AW - COUNT_ALIGN - LINE_ALIGN;

    typedef logic [FETCH_AW-1:0]    addr_t;
    typedef logic [ID_WIDTH-1:0]    id_t;
    typedef logic [COUNT_ALIGN-1:0] line_idx_t;
    typedef logic [SET_ALIGN-1:0]   set_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [LINE_WIDTH-1:0]  line_t;

    // Data RAM word address, set number in the upper bits
    typedef logic [SET_ALIGN+COUNT_ALIGN-1:0] data_addr_t;

    // Stored tag word: valid, error, tag from MSB down
    typedef logic [TAG_WIDTH+1:0] tag_entry_t;

endpackage

`default_nettype wire

// File: common/icache_types_pkg.sv
// --------------------------------------------------
// Instruction cache lookup payloads
// Structs exchanged by the ports and the two stages
// --------------------------------------------------
`default_nettype none

package icache_types_pkg;

    typedef struct packed {
        icache_cfg_pkg::addr_t addr;
        icache_cfg_pkg::id_t   id;
    } lookup_req_t;

    // Result of the tag compare
    typedef struct packed {
        icache_cfg_pkg::set_t cset;
        logic                 hit;
        logic                 error;
    } tag_rsp_t;

    typedef struct packed {
        icache_cfg_pkg::addr_t addr;
        icache_cfg_pkg::id_t   id;
        icache_cfg_pkg::set_t  cset;
        logic                  hit;
        logic                  error;
    } data_req_t;

    // One refill line with its placement
    typedef struct packed {
        icache_cfg_pkg::line_idx_t idx;
        icache_cfg_pkg::set_t      cset;
        icache_cfg_pkg::tag_t      tag;
        logic                      error;
        icache_cfg_pkg::line_t     data;
    } refill_t;

    typedef struct packed {
        icache_cfg_pkg::addr_t addr;
        icache_cfg_pkg::id_t   id;
        icache_cfg_pkg::set_t  cset;
        logic                  hit;
        logic                  error;
        icache_cfg_pkg::line_t data;
    } lookup_rsp_t;

endpackage

`default_nettype wire

// File: hw/icache_sram.sv
// --------------------------------------------------
// Behavioral single-port SRAM
// One-cycle read latency, per-lane write enables
// --------------------------------------------------
`default_nettype none

module icache_sram #(
    parameter int unsigned NUM_WORDS  = 16,
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned LANE_WIDTH = 8
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             req_i,
    input  logic                             we_i,
    input  logic [$clog2(NUM_WORDS)-1:0]     addr_i,
    input  logic [DATA_WIDTH/LANE_WIDTH-1:0] be_i,
    input  logic [DATA_WIDTH-1:0]            wdata_i,
    output logic [DATA_WIDTH-1:0]            rdata_o
);

    logic [DATA_WIDTH-1:0] mem_q [NUM_WORDS];
    logic [DATA_WIDTH-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int i = 0; i < DATA_WIDTH / LANE_WIDTH; i++) begin
                if (be_i[i]) begin
                    mem_q[addr_i][i*LANE_WIDTH +: LANE_WIDTH] <= wdata_i[i*LANE_WIDTH +: LANE_WIDTH];
                end
            end
        end
    end

    // Read data holds until the next read, writes leave it alone
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (req_i && !we_i) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/icache_lookup/icache_tag_stage.sv
// --------------------------------------------------
// Instruction cache tag stage
// Init sweep, tag port arbitration, hit compare
// and a fall-through buffer for the tag response
// --------------------------------------------------
`default_nettype none

module icache_tag_stage (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  icache_types_pkg::lookup_req_t in_req_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  icache_types_pkg::refill_t     refill_i,
    input  logic                          write_valid_i,
    output logic                          write_ready_o,
    output logic                          init_busy_o,
    input  icache_cfg_pkg::data_addr_t    lookup_addr_i,
    output icache_types_pkg::lookup_req_t tag_req_o,
    output icache_types_pkg::tag_rsp_t    tag_rsp_o,
    output logic                          tag_valid_o,
    input  logic                          tag_ready_i,
    output logic                          ram_req_o,
    output logic                          ram_we_o,
    output icache_cfg_pkg::line_idx_t     ram_addr_o,
    output logic [icache_cfg_pkg::SET_COUNT-1:0] ram_be_o,
    output icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::SET_COUNT-1:0] ram_wdata_o,
    input  icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::SET_COUNT-1:0] ram_rdata_i
);

    logic [icache_cfg_pkg::COUNT_ALIGN:0] init_count_q;

    logic                          accept;
    logic                          req_ready;
    logic                          tag_valid_q;
    logic                          req_handshake_q;
    icache_types_pkg::lookup_req_t tag_req_q;

    icache_cfg_pkg::tag_t          req_tag;
    logic [icache_cfg_pkg::SET_COUNT-1:0] line_hit;
    logic [icache_cfg_pkg::SET_COUNT-1:0] line_err;
    icache_types_pkg::tag_rsp_t    tag_rsp_s;
    icache_types_pkg::tag_rsp_t    tag_rsp_d;
    icache_types_pkg::tag_rsp_t    tag_rsp_q;

    // --------------------------------------------------
    // Init and flush sweep
    // --------------------------------------------------
    // The counter walks every line once, flush restarts it when idle
    assign init_busy_o = init_count_q != (icache_cfg_pkg::COUNT_ALIGN + 1)'(
        icache_cfg_pkg::LINE_COUNT);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_count_q <= '0;
        end else if (init_busy_o) begin
            init_count_q <= init_count_q + 1'b1;
        end else if (flush_i) begin
            init_count_q <= '0;
        end
    end

    // --------------------------------------------------
    // Tag port arbitration
    // --------------------------------------------------
    // A lookup may enter when the output slot is free or being drained
    assign req_ready = !tag_valid_q || tag_ready_i;
    assign accept    = in_valid_i && in_ready_o;

    always_comb begin
        ram_req_o     = 1'b0;
        ram_we_o      = 1'b0;
        ram_addr_o    = in_req_i.addr[icache_cfg_pkg::LINE_ALIGN +: icache_cfg_pkg::COUNT_ALIGN];
        ram_be_o      = '1;
        ram_wdata_o   = {icache_cfg_pkg::SET_COUNT{{1'b1, refill_i.error, refill_i.tag}}};
        write_ready_o = 1'b0;
        in_ready_o    = 1'b0;

        if (init_busy_o) begin
            // Clear all sets of the current line
            ram_req_o   = 1'b1;
            ram_we_o    = 1'b1;
            ram_addr_o  = init_count_q[icache_cfg_pkg::COUNT_ALIGN-1:0];
            ram_wdata_o = '0;
        end else if (write_valid_i) begin
            ram_req_o            = 1'b1;
            ram_we_o             = 1'b1;
            ram_addr_o           = refill_i.idx;
            ram_be_o             = '0;
            ram_be_o[refill_i.cset] = 1'b1;
            write_ready_o        = 1'b1;
        end else begin
            in_ready_o = req_ready;
            ram_req_o  = in_valid_i && req_ready;
        end
    end

    // --------------------------------------------------
    // Hit compare
    // --------------------------------------------------
    assign req_tag = tag_req_q.addr[icache_cfg_pkg::FETCH_AW-1 -: icache_cfg_pkg::TAG_WIDTH];

    always_comb begin
        tag_rsp_s = '0;
        for (int i = 0; i < icache_cfg_pkg::SET_COUNT; i++) begin
            line_hit[i] = ram_rdata_i[i][icache_cfg_pkg::TAG_WIDTH+1] &&
                          ram_rdata_i[i][icache_cfg_pkg::TAG_WIDTH-1:0] == req_tag;
            line_err[i] = line_hit[i] && ram_rdata_i[i][icache_cfg_pkg::TAG_WIDTH];
        end
        // Walk downwards so the lowest matching set wins
        for (int i = icache_cfg_pkg::SET_COUNT - 1; i >= 0; i--) begin
            if (line_hit[i]) begin
                tag_rsp_s.cset = icache_cfg_pkg::set_t'(i);
            end
        end
        tag_rsp_s.hit   = |line_hit;
        tag_rsp_s.error = |line_err;
    end

    // --------------------------------------------------
    // Pipeline register and fall-through buffer
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_valid_q     <= 1'b0;
            req_handshake_q <= 1'b0;
        end else begin
            req_handshake_q <= accept;
            if (accept) begin
                tag_valid_q <= 1'b1;
            end else if (tag_ready_i) begin
                tag_valid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        tag_rsp_d = tag_rsp_q;
        // Keep the fresh compare result when the data stage stalls
        if (req_handshake_q && !tag_ready_i) begin
            tag_rsp_d = tag_rsp_s;
        end
        // A refill to the waiting line makes its hit stale
        if (write_valid_i && !init_busy_o && lookup_addr_i == {refill_i.cset, refill_i.idx}) begin
            tag_rsp_d.hit = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        tag_rsp_q <= tag_rsp_d;
        if (accept) begin
            tag_req_q <= in_req_i;
        end
    end

    assign tag_req_o   = tag_req_q;
    assign tag_rsp_o   = req_handshake_q ? tag_rsp_s : tag_rsp_q;
    assign tag_valid_o = tag_valid_q;

endmodule

`default_nettype wire

// File: hw/icache_lookup/icache_data_stage.sv
// --------------------------------------------------
// Instruction cache data stage
// Reads the line on a hit and holds the response
// --------------------------------------------------
`default_nettype none

module icache_data_stage (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          init_busy_i,
    input  icache_types_pkg::lookup_req_t tag_req_i,
    input  icache_types_pkg::tag_rsp_t    tag_rsp_i,
    input  logic                          tag_valid_i,
    output logic                          tag_ready_o,
    input  icache_types_pkg::refill_t     refill_i,
    input  logic                          write_valid_i,
    output icache_cfg_pkg::data_addr_t    lookup_addr_o,
    output icache_types_pkg::lookup_rsp_t out_rsp_o,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    output logic                          ram_req_o,
    output logic                          ram_we_o,
    output icache_cfg_pkg::data_addr_t    ram_addr_o,
    output icache_cfg_pkg::line_t         ram_wdata_o,
    input  icache_cfg_pkg::line_t         ram_rdata_i
);

    logic                        data_write;
    logic                        tag_handshake;
    logic                        out_valid_q;
    logic                        rd_handshake_q;
    icache_types_pkg::data_req_t data_req_d;
    icache_types_pkg::data_req_t data_req_q;
    icache_cfg_pkg::line_t       line_q;

    assign data_req_d.addr  = tag_req_i.addr;
    assign data_req_d.id    = tag_req_i.id;
    assign data_req_d.cset  = tag_rsp_i.cset;
    assign data_req_d.hit   = tag_rsp_i.hit;
    assign data_req_d.error = tag_rsp_i.error;

    assign lookup_addr_o = {tag_rsp_i.cset,
        tag_req_i.addr[icache_cfg_pkg::LINE_ALIGN +: icache_cfg_pkg::COUNT_ALIGN]};

    // --------------------------------------------------
    // Data port arbitration
    // --------------------------------------------------
    // Refill writes own the port, so the tag stage waits for them
    assign data_write    = write_valid_i && !init_busy_i;
    assign tag_ready_o   = (!out_valid_q || out_ready_i) && !data_write;
    assign tag_handshake = tag_valid_i && tag_ready_o;

    always_comb begin
        ram_req_o   = tag_handshake && tag_rsp_i.hit;
        ram_we_o    = 1'b0;
        ram_addr_o  = lookup_addr_o;
        ram_wdata_o = refill_i.data;
        if (data_write) begin
            ram_req_o  = 1'b1;
            ram_we_o   = 1'b1;
            ram_addr_o = {refill_i.cset, refill_i.idx};
        end
    end

    // --------------------------------------------------
    // Request register and read-data buffer
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_q    <= 1'b0;
            rd_handshake_q <= 1'b0;
        end else begin
            rd_handshake_q <= tag_handshake && tag_rsp_i.hit;
            if (tag_handshake) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (tag_handshake) begin
            data_req_q <= data_req_d;
        end
        // The RAM output is live for one cycle only, so catch it on a stall
        if (rd_handshake_q && !out_ready_i) begin
            line_q <= ram_rdata_i;
        end
    end

    always_comb begin
        out_rsp_o.addr  = data_req_q.addr;
        out_rsp_o.id    = data_req_q.id;
        out_rsp_o.cset  = data_req_q.cset;
        out_rsp_o.hit   = data_req_q.hit;
        out_rsp_o.error = data_req_q.error;
        out_rsp_o.data  = rd_handshake_q ? ram_rdata_i : line_q;
    end

    assign out_valid_o = out_valid_q;

endmodule

`default_nettype wire

// File: hw/icache_lookup/icache_lookup.sv
// --------------------------------------------------
// Instruction cache lookup pipeline
// Tag stage and data stage with their two SRAMs
// --------------------------------------------------
`default_nettype none

module icache_lookup (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          flush_i,
    input  icache_types_pkg::lookup_req_t in_req_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    output icache_types_pkg::lookup_rsp_t out_rsp_o,
    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    input  icache_types_pkg::refill_t     refill_i,
    input  logic                          write_valid_i,
    output logic                          write_ready_o
);

    icache_types_pkg::lookup_req_t tag_req;
    icache_types_pkg::tag_rsp_t    tag_rsp;
    logic                          tag_valid;
    logic                          tag_ready;
    logic                          init_busy;
    icache_cfg_pkg::data_addr_t    lookup_addr;

    // Tag RAM port, one lane per set
    logic                                                   tag_ram_req;
    logic                                                   tag_ram_we;
    icache_cfg_pkg::line_idx_t                              tag_ram_addr;
    logic [icache_cfg_pkg::SET_COUNT-1:0]                   tag_ram_be;
    icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::SET_COUNT-1:0] tag_ram_wdata;
    icache_cfg_pkg::tag_entry_t [icache_cfg_pkg::SET_COUNT-1:0] tag_ram_rdata;

    // Data RAM port
    logic                       data_ram_req;
    logic                       data_ram_we;
    icache_cfg_pkg::data_addr_t data_ram_addr;
    icache_cfg_pkg::line_t      data_ram_wdata;
    icache_cfg_pkg::line_t      data_ram_rdata;

    icache_tag_stage u_tag_stage (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .in_req_i      (in_req_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .refill_i      (refill_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o),
        .init_busy_o   (init_busy),
        .lookup_addr_i (lookup_addr),
        .tag_req_o     (tag_req),
        .tag_rsp_o     (tag_rsp),
        .tag_valid_o   (tag_valid),
        .tag_ready_i   (tag_ready),
        .ram_req_o     (tag_ram_req),
        .ram_we_o      (tag_ram_we),
        .ram_addr_o    (tag_ram_addr),
        .ram_be_o      (tag_ram_be),
        .ram_wdata_o   (tag_ram_wdata),
        .ram_rdata_i   (tag_ram_rdata)
    );

    icache_data_stage u_data_stage (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .init_busy_i   (init_busy),
        .tag_req_i     (tag_req),
        .tag_rsp_i     (tag_rsp),
        .tag_valid_i   (tag_valid),
        .tag_ready_o   (tag_ready),
        .refill_i      (refill_i),
        .write_valid_i (write_valid_i),
        .lookup_addr_o (lookup_addr),
        .out_rsp_o     (out_rsp_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .ram_req_o     (data_ram_req),
        .ram_we_o      (data_ram_we),
        .ram_addr_o    (data_ram_addr),
        .ram_wdata_o   (data_ram_wdata),
        .ram_rdata_i   (data_ram_rdata)
    );

    icache_sram #(
        .NUM_WORDS  (icache_cfg_pkg::LINE_COUNT),
        .DATA_WIDTH (icache_cfg_pkg::SET_COUNT * $bits(icache_cfg_pkg::tag_entry_t)),
        .LANE_WIDTH ($bits(icache_cfg_pkg::tag_entry_t))
    ) u_tag_ram (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (tag_ram_req),
        .we_i    (tag_ram_we),
        .addr_i  (tag_ram_addr),
        .be_i    (tag_ram_be),
        .wdata_i (tag_ram_wdata),
        .rdata_o (tag_ram_rdata)
    );

    // Whole lines are written, so the single lane is always enabled
    icache_sram #(
        .NUM_WORDS  (icache_cfg_pkg::LINE_COUNT * icache_cfg_pkg::SET_COUNT),
        .DATA_WIDTH (icache_cfg_pkg::LINE_WIDTH),
        .LANE_WIDTH (icache_cfg_pkg::LINE_WIDTH)
    ) u_data_ram (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (data_ram_req),
        .we_i    (data_ram_we),
        .addr_i  (data_ram_addr),
        .be_i    (1'b1),
        .wdata_i (data_ram_wdata),
        .rdata_o (data_ram_rdata)
    );

endmodule

`default_nettype wire

// File: verification/icache_lookup_properties.sv
// --------------------------------------------------
// Port properties of the instruction cache lookup
// Bound into the top level by the testbench
// --------------------------------------------------
`default_nettype none

module icache_lookup_properties (
    input wire logic                          clk_i,
    input wire logic                          rst_ni,
    input wire logic                          in_ready_o,
    input wire icache_types_pkg::lookup_rsp_t out_rsp_o,
    input wire logic                          out_valid_o,
    input wire logic                          out_ready_i,
    input wire logic                          write_valid_i,
    input wire logic                          write_ready_o
);

    // A stalled response keeps its valid and its contents
    property p_rsp_stable;
        @(posedge clk_i) disable iff (!rst_ni)
            out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rsp_o);
    endproperty

    property p_write_ready_needs_valid;
        @(posedge clk_i) disable iff (!rst_ni)
            write_ready_o |-> write_valid_i;
    endproperty

    // Writes own the tag port, so a lookup is never accepted alongside one
    property p_ready_exclusive;
        @(posedge clk_i) disable iff (!rst_ni)
            !(in_ready_o && write_ready_o);
    endproperty

    a_rsp_stable: assert property (p_rsp_stable)
        else $error("out_rsp_o changed while the response was stalled");
    a_write_ready_needs_valid: assert property (p_write_ready_needs_valid)
        else $error("write_ready_o high without write_valid_i");
    a_ready_exclusive: assert property (p_ready_exclusive)
        else $error("in_ready_o and write_ready_o high in the same cycle");

endmodule

`default_nettype wire

// File: verification/icache_lookup_tb.sv
// --------------------------------------------------
// Testbench for the instruction cache lookup
// Random lookups and refills checked against a model
// --------------------------------------------------
`default_nettype none

module icache_lookup_tb;

    localparam int SEED = 65;
    // Lookups, refills and flushes issued by all tests together
    localparam int TOTAL_OPS = 169;

    logic                          clk_i = 1'b0;
    logic                          rst_ni;
    logic                          flush_i;
    icache_types_pkg::lookup_req_t in_req_i;
    logic                          in_valid_i;
    logic                          in_ready_o;
    icache_types_pkg::lookup_rsp_t out_rsp_o;
    logic                          out_valid_o;
    logic                          out_ready_i;
    icache_types_pkg::refill_t     refill_i;
    logic                          write_valid_i;
    logic                          write_ready_o;

    // Reference model of the tag and data arrays
    icache_cfg_pkg::tag_t  m_tag   [icache_cfg_pkg::LINE_COUNT][icache_cfg_pkg::SET_COUNT];
    logic                  m_valid [icache_cfg_pkg::LINE_COUNT][icache_cfg_pkg::SET_COUNT];
    logic                  m_err   [icache_cfg_pkg::LINE_COUNT][icache_cfg_pkg::SET_COUNT];
    icache_cfg_pkg::line_t m_data  [icache_cfg_pkg::LINE_COUNT][icache_cfg_pkg::SET_COUNT];

    icache_types_pkg::lookup_rsp_t exp_q[$];
    icache_types_pkg::lookup_rsp_t mon_exp;

    int          seed;
    int          ready_seed;
    int          n_checks;
    int          n_errors;
    int          test_errors;
    string       cur_test;
    logic        bp_mode;
    logic [31:0] ready_rnd;
    logic [31:0] stim;

    icache_lookup u_icache_lookup (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .in_req_i      (in_req_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .out_rsp_o     (out_rsp_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .refill_i      (refill_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o)
    );

    bind icache_lookup icache_lookup_properties u_properties (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .in_ready_o    (in_ready_o),
        .out_rsp_o     (out_rsp_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .write_valid_i (write_valid_i),
        .write_ready_o (write_ready_o)
    );

    always #20 clk_i = ~clk_i;

    // --------------------------------------------------
    // Model and compare tasks
    // --------------------------------------------------
    task automatic model_clear();
        for (int i = 0; i < icache_cfg_pkg::LINE_COUNT; i++) begin
            for (int s = 0; s < icache_cfg_pkg::SET_COUNT; s++) begin
                m_valid[i][s] = 1'b0;
            end
        end
    endtask

    // First valid set with an equal tag supplies set and data, errors of all matches add up
    function automatic icache_types_pkg::lookup_rsp_t model_lookup(
        icache_types_pkg::lookup_req_t req
    );
        icache_types_pkg::lookup_rsp_t rsp;
        icache_cfg_pkg::line_idx_t     idx;
        icache_cfg_pkg::tag_t          tag;
        rsp      = '0;
        rsp.addr = req.addr;
        rsp.id   = req.id;
        idx = req.addr[icache_cfg_pkg::LINE_ALIGN +: icache_cfg_pkg::COUNT_ALIGN];
        tag = req.addr[icache_cfg_pkg::FETCH_AW-1 -: icache_cfg_pkg::TAG_WIDTH];
        for (int s = 0; s < icache_cfg_pkg::SET_COUNT; s++) begin
            if (m_valid[idx][s] && m_tag[idx][s] == tag) begin
                if (!rsp.hit) begin
                    rsp.cset = icache_cfg_pkg::set_t'(s);
                    rsp.data = m_data[idx][s];
                end
                rsp.hit   = 1'b1;
                rsp.error = rsp.error | m_err[idx][s];
            end
        end
        return rsp;
    endfunction

    task automatic check_hit(string what, logic exp, logic act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERROR %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_set(string what, icache_cfg_pkg::set_t exp, icache_cfg_pkg::set_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERROR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_line(string what, icache_cfg_pkg::line_t exp, icache_cfg_pkg::line_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_id(string what, icache_cfg_pkg::id_t exp, icache_cfg_pkg::id_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_addr(string what, icache_cfg_pkg::addr_t exp, icache_cfg_pkg::addr_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // Responses are sampled mid-cycle and transfer on the next rising edge
    always @(negedge clk_i) begin
        if (rst_ni && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("Unexpected response in %s with no lookup outstanding", cur_test);
            end else begin
                mon_exp = exp_q.pop_front();
                check_addr("addr", mon_exp.addr, out_rsp_o.addr);
                check_id("id", mon_exp.id, out_rsp_o.id);
                check_hit("hit", mon_exp.hit, out_rsp_o.hit);
                check_hit("error", mon_exp.error, out_rsp_o.error);
                if (mon_exp.hit) begin
                    check_set("set", mon_exp.cset, out_rsp_o.cset);
                    check_line("data", mon_exp.data, out_rsp_o.data);
                end
            end
        end
    end

    always @(posedge clk_i) begin
        #1;
        ready_rnd   = $random(ready_seed);
        out_ready_i = bp_mode ? ready_rnd[0] : 1'b1;
    end

    // --------------------------------------------------
    // Stimulus tasks, all entered just after a rising edge
    // --------------------------------------------------
    function automatic icache_cfg_pkg::addr_t rand_addr(int unsigned tags, int unsigned lines);
        logic [31:0]               r;
        icache_cfg_pkg::tag_t      tag;
        icache_cfg_pkg::line_idx_t idx;
        r   = $random(seed);
        tag = icache_cfg_pkg::tag_t'(r[31:16] % tags);
        idx = icache_cfg_pkg::line_idx_t'(r[15:8] % lines);
        return {tag, idx, r[icache_cfg_pkg::LINE_ALIGN-1:0]};
    endfunction

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic do_lookup(icache_cfg_pkg::addr_t addr);
        logic [31:0] r;
        logic        accepted;
        r             = $random(seed);
        in_req_i.addr = addr;
        in_req_i.id   = icache_cfg_pkg::id_t'(r);
        in_valid_i    = 1'b1;
        exp_q.push_back(model_lookup(in_req_i));
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = in_ready_o;
            @(posedge clk_i);
            #1;
        end
        in_valid_i = 1'b0;
    endtask

    task automatic do_refill(icache_cfg_pkg::line_idx_t idx, icache_cfg_pkg::set_t cset,
                             icache_cfg_pkg::tag_t tag);
        logic [31:0] r0;
        logic [31:0] r1;
        logic        accepted;
        wait_drained();
        r0             = $random(seed);
        r1             = $random(seed);
        refill_i.idx   = idx;
        refill_i.cset  = cset;
        refill_i.tag   = tag;
        refill_i.error = r0[0];
        refill_i.data  = {r0, r1};
        write_valid_i  = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_i);
            accepted = write_ready_o;
            @(posedge clk_i);
            #1;
        end
        write_valid_i      = 1'b0;
        m_valid[idx][cset] = 1'b1;
        m_tag[idx][cset]   = tag;
        m_err[idx][cset]   = refill_i.error;
        m_data[idx][cset]  = refill_i.data;
    endtask

    task automatic do_flush();
        wait_drained();
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        model_clear();
    endtask

    task automatic start_test(string name);
        cur_test    = name;
        test_errors = n_errors;
    endtask

    task automatic end_test();
        wait_drained();
        if (n_errors == test_errors) begin
            $display("Test %s: ok", cur_test);
        end else begin
            $display("Test %s: %0d mismatches", cur_test, n_errors - test_errors);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed          = SEED;
        ready_seed    = SEED;
        n_checks      = 0;
        n_errors      = 0;
        bp_mode       = 1'b0;
        cur_test      = "reset";
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        in_req_i      = '0;
        in_valid_i    = 1'b0;
        out_ready_i   = 1'b0;
        refill_i      = '0;
        write_valid_i = 1'b0;
        model_clear();
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        start_test("cold_miss");
        repeat (20) do_lookup($random(seed));
        end_test();

        start_test("refill_hit");
        for (int i = 0; i < 8; i++) begin
            stim = $random(seed);
            do_refill(icache_cfg_pkg::line_idx_t'(i), stim[0], icache_cfg_pkg::tag_t'(stim[9:8]));
        end
        repeat (20) do_lookup(rand_addr(8, 8));
        end_test();

        // Two tags on four lines puts different tags in both sets of one index
        start_test("random_traffic");
        repeat (60) begin
            stim = $random(seed);
            if (stim[1:0] == 2'd0) begin
                do_refill(icache_cfg_pkg::line_idx_t'(stim[5:4]), stim[8],
                          icache_cfg_pkg::tag_t'(stim[12]));
            end else begin
                do_lookup(rand_addr(2, 4));
            end
        end
        end_test();

        start_test("back_pressure");
        bp_mode = 1'b1;
        repeat (40) do_lookup(rand_addr(4, 8));
        end_test();
        bp_mode = 1'b0;

        start_test("flush");
        for (int i = 0; i < 4; i++) begin
            do_refill(icache_cfg_pkg::line_idx_t'(i), i[0], '0);
        end
        repeat (8) do_lookup(rand_addr(1, 4));
        do_flush();
        repeat (8) do_lookup(rand_addr(1, 4));
        end_test();

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_OPS * 20) @(posedge clk_i);
        $display("Watchdog expired: the tests did not finish within %0d cycles", TOTAL_OPS * 20);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
common/icache_cfg_pkg.sv
common/icache_types_pkg.sv
hw/icache_sram.sv
hw/icache_lookup/icache_tag_stage.sv
hw/icache_lookup/icache_data_stage.sv
hw/icache_lookup/icache_lookup.sv
verification/icache_lookup_properties.sv
verification/icache_lookup_tb.sv

// File: Makefile
# Verilator build and run of the instruction cache lookup testbench

VERILATOR ?= verilator
TOP       ?= icache_lookup_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The run fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
